/* Bender.yml */
package:
  name: psum_collect

sources:
  - files:
      - hw/collect_pkg.sv
      - hw/collect_sequencer.sv
      - hw/lane_select_mux.sv
      - hw/collect_fifo.sv
      - hw/psum_accumulator.sv
      - hw/psum_collect_top.sv
  - target: test
    files:
      - verification/psum_collect_checker.sv
      - verification/psum_collect_tb.sv

/* hw/collect_fifo.sv */
`timescale 1ns/1ps

module collect_fifo #(
	parameter int DATA_WIDTH = 32,
	parameter int FIFO_DEPTH = 4
)
(
	input  logic                      clk,
	input  logic                      i_rst,
	input  logic                      i_push,
	input  collect_pkg::psum_entry_t  i_entry,
	input  logic                      i_pop,
	output collect_pkg::psum_entry_t  o_head,
	output logic                      o_empty,
	output logic                      o_almost_full
);
	localparam int PTR_W   = $clog2(FIFO_DEPTH);
	localparam int ENTRY_W = DATA_WIDTH + 2; // data plus valid and last

	logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [PTR_W:0]     count;
	logic               do_pop;

	assign do_pop  = i_pop && !o_empty;
	assign o_empty = (count == '0);
	assign o_head  = mem[rd_ptr];

	// room for one entry in flight through the mux plus the next select
	assign o_almost_full = (count + 1'b1) >= FIFO_DEPTH;

	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({i_push, do_pop})
				2'b10:
				begin
					count <= count + 1'b1;
				end
				2'b01:
				begin
					count <= count - 1'b1;
				end
				default:
				begin
					count <= count;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_push)
			mem[wr_ptr] <= i_entry;
	end

endmodule

/* hw/collect_pkg.sv */
package collect_pkg;

	// lane count of the reduction network
	localparam int NUM_LANES  = 8;

	// entry payload width, matches the default DATA_WIDTH of the modules
	localparam int PSUM_WIDTH = 32;

	typedef logic [2:0] lane_idx_t;

	// one collected partial sum as held in the FIFO
	typedef struct packed
	{
		logic                  valid; // lane was valid when selected
		logic                  last;  // closes the group
		logic [PSUM_WIDTH-1:0] data;
	} psum_entry_t;

	// order[0] is issued first
	typedef struct packed
	{
		logic [3:0]                   count; // 1..8 entries
		lane_idx_t [NUM_LANES-1:0]    order;
	} collect_plan_t;

	typedef enum logic [1:0]
	{
		SEQ_IDLE,
		SEQ_ISSUE,
		SEQ_STALL
	} seq_state_t;

endpackage

/* hw/collect_sequencer.sv */
`timescale 1ns/1ps

module collect_sequencer
(
	input  logic                                clk,
	input  logic                                i_rst,
	input  logic                                i_start,
	input  collect_pkg::collect_plan_t          i_plan,
	input  logic                                i_almost_full,
	output logic                                o_sel_en,
	output logic [collect_pkg::NUM_LANES-1:0]   o_sel,
	output logic                                o_push,
	output logic                                o_last,
	output logic                                o_busy
);
	import collect_pkg::*;

	seq_state_t    state;
	seq_state_t    state_next;
	collect_plan_t plan_q;
	lane_idx_t     idx;
	logic          sel_last;
	logic          start_ok;

	assign start_ok = (state == SEQ_IDLE) && i_start && !o_busy;

	// idx+1 reaching count marks the final select
	assign sel_last = ({1'b0, idx} + 4'd1) >= plan_q.count;

	// one select per cycle unless the FIFO is close to full
	assign o_sel_en = (state != SEQ_IDLE) && !i_almost_full;
	assign o_sel    = o_sel_en ? (NUM_LANES'(1) << plan_q.order[idx]) : '0;

	// stays up until the last entry has been pushed
	assign o_busy = (state != SEQ_IDLE) || o_push;

	always_comb
	begin
		state_next = state;
		case (state)
			SEQ_IDLE:
			begin
				if (start_ok)
					state_next = SEQ_ISSUE;
			end
			SEQ_ISSUE, SEQ_STALL:
			begin
				if (i_almost_full)
					state_next = SEQ_STALL;
				else if (sel_last)
					state_next = SEQ_IDLE;
				else
					state_next = SEQ_ISSUE;
			end
			default:
			begin
				state_next = SEQ_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			state  <= SEQ_IDLE;
			idx    <= '0;
			o_push <= 1'b0;
			o_last <= 1'b0;
		end
		else
		begin
			state  <= state_next;
			o_push <= o_sel_en;             // lines up with mux output
			o_last <= o_sel_en && sel_last;
			if (state == SEQ_IDLE)
				idx <= '0;
			else if (o_sel_en)
				idx <= idx + 1'b1;
		end
	end

	// plan held for the whole run
	always_ff @(posedge clk)
	begin
		if (start_ok)
			plan_q <= i_plan;
	end

endmodule

/* hw/lane_select_mux.sv */
`timescale 1ns/1ps

module lane_select_mux #(
	parameter int DATA_WIDTH = 32
)
(
	input  logic                                        clk,
	input  logic                                        i_rst,
	input  logic                                        i_en,
	input  logic [collect_pkg::NUM_LANES-1:0]           i_sel,      // one-hot
	input  logic [collect_pkg::NUM_LANES-1:0]           i_valid,
	input  logic [collect_pkg::NUM_LANES*DATA_WIDTH-1:0] i_data_bus,
	output logic                                        o_valid,
	output logic [DATA_WIDTH-1:0]                       o_data
);
	import collect_pkg::*;

	logic                  sel_onehot;
	logic                  sel_valid;
	logic [DATA_WIDTH-1:0] sel_data;

	// exactly one bit set
	assign sel_onehot = (i_sel != '0) && ((i_sel & (i_sel - 1'b1)) == '0);

	// and-or select, safe since the select is checked one-hot below
	always_comb
	begin
		sel_valid = 1'b0;
		sel_data  = '0;
		for (int k = 0; k < NUM_LANES; k++)
		begin
			if (i_sel[k])
			begin
				sel_valid = sel_valid | i_valid[k];
				sel_data  = sel_data | i_data_bus[k*DATA_WIDTH +: DATA_WIDTH];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			o_valid <= 1'b0;
			o_data  <= '0;
		end
		else if (!i_en || !sel_onehot)
		begin
			o_valid <= 1'b0;  // disabled or bad select
			o_data  <= '0;
		end
		else
		begin
			o_valid <= sel_valid;
			o_data  <= sel_valid ? sel_data : '0; // invalid lane adds zero
		end
	end

endmodule

/* hw/psum_accumulator.sv */
`timescale 1ns/1ps

module psum_accumulator #(
	parameter int DATA_WIDTH = 32,
	parameter int SUM_WIDTH  = DATA_WIDTH + 3
)
(
	input  logic                      clk,
	input  logic                      i_rst,
	input  logic                      i_empty,
	input  collect_pkg::psum_entry_t  i_head,
	input  logic                      i_hold,
	output logic                      o_pop,
	output logic                      o_sum_valid,
	output logic [SUM_WIDTH-1:0]      o_sum,
	output logic [3:0]                o_sum_count
);
	logic [SUM_WIDTH-1:0]  acc;
	logic [SUM_WIDTH-1:0]  acc_next;
	logic [3:0]            cnt;
	logic [3:0]            cnt_next;
	logic [DATA_WIDTH-1:0] head_data;

	// drain whenever something is there and not held
	assign o_pop = !i_empty && !i_hold;

	assign head_data = i_head.data[DATA_WIDTH-1:0];
	assign acc_next  = acc + {{(SUM_WIDTH-DATA_WIDTH){1'b0}}, head_data}; // zero-extended
	assign cnt_next  = cnt + {3'b000, i_head.valid};

	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			acc         <= '0;
			cnt         <= '0;
			o_sum_valid <= 1'b0;
			o_sum       <= '0;
			o_sum_count <= '0;
		end
		else
		begin
			o_sum_valid <= 1'b0;
			if (o_pop)
			begin
				if (i_head.last)
				begin
					// publish the group and start over
					o_sum       <= acc_next;
					o_sum_count <= cnt_next;
					o_sum_valid <= 1'b1;
					acc         <= '0;
					cnt         <= '0;
				end
				else
				begin
					acc <= acc_next;
					cnt <= cnt_next;
				end
			end
		end
	end

endmodule

/* hw/psum_collect_top.sv */
`timescale 1ns/1ps

module psum_collect_top #(
	parameter int DATA_WIDTH = 32,
	parameter int FIFO_DEPTH = 4,
	parameter int SUM_WIDTH  = DATA_WIDTH + 3
)
(
	input  logic                                         clk,
	input  logic                                         i_rst,
	input  logic                                         i_start,
	input  collect_pkg::collect_plan_t                   i_plan,
	input  logic [collect_pkg::NUM_LANES-1:0]            i_lane_valid,
	input  logic [collect_pkg::NUM_LANES*DATA_WIDTH-1:0] i_lane_data,
	input  logic                                         i_hold,
	output logic                                         o_busy,
	output logic                                         o_sum_valid,
	output logic [SUM_WIDTH-1:0]                         o_sum,
	output logic [3:0]                                   o_sum_count
);
	import collect_pkg::*;

	logic                  sel_en;
	logic [NUM_LANES-1:0]  sel;
	logic                  push;
	logic                  last;
	logic                  almost_full;
	logic                  mux_valid;
	logic [DATA_WIDTH-1:0] mux_data;
	logic                  fifo_empty;
	logic                  pop;
	psum_entry_t           fifo_in;
	psum_entry_t           fifo_head;

	// mux output joined with the delayed last flag
	assign fifo_in.valid = mux_valid;
	assign fifo_in.last  = last;
	assign fifo_in.data  = mux_data;

	collect_sequencer u_seq (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_start       (i_start),
		.i_plan        (i_plan),
		.i_almost_full (almost_full),
		.o_sel_en      (sel_en),
		.o_sel         (sel),
		.o_push        (push),
		.o_last        (last),
		.o_busy        (o_busy)
	);

	lane_select_mux #(.DATA_WIDTH(DATA_WIDTH)) u_mux (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_en       (sel_en),
		.i_sel      (sel),
		.i_valid    (i_lane_valid),
		.i_data_bus (i_lane_data),
		.o_valid    (mux_valid),
		.o_data     (mux_data)
	);

	collect_fifo #(.DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk           (clk),
		.i_rst         (i_rst),
		.i_push        (push),
		.i_entry       (fifo_in),
		.i_pop         (pop),
		.o_head        (fifo_head),
		.o_empty       (fifo_empty),
		.o_almost_full (almost_full)
	);

	psum_accumulator #(.DATA_WIDTH(DATA_WIDTH), .SUM_WIDTH(SUM_WIDTH)) u_acc (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_empty     (fifo_empty),
		.i_head      (fifo_head),
		.i_hold      (i_hold),
		.o_pop       (pop),
		.o_sum_valid (o_sum_valid),
		.o_sum       (o_sum),
		.o_sum_count (o_sum_count)
	);

endmodule

/* psum_collect_top.f */
hw/collect_pkg.sv
hw/collect_sequencer.sv
hw/lane_select_mux.sv
hw/collect_fifo.sv
hw/psum_accumulator.sv
hw/psum_collect_top.sv
verification/psum_collect_checker.sv
verification/psum_collect_tb.sv

/* verification/psum_collect_checker.sv */
`timescale 1ns/1ps

module psum_collect_checker
(
	input logic       clk,
	input logic       i_rst,
	input logic       i_busy,
	input logic       i_sum_valid,
	input logic [3:0] i_sum_count
);
	// assertion failures seen so far
	int unsigned fail_count = 0;

	sum_valid_low_in_reset: assert property (@(posedge clk) i_rst |=> !i_sum_valid)
	else
	begin
		$error("result pulse while in reset");
		fail_count++;
	end

	// one pulse per group, never two in a row
	sum_valid_single: assert property (@(posedge clk) disable iff (i_rst)
		i_sum_valid |=> !i_sum_valid)
	else
	begin
		$error("result pulse held for two cycles");
		fail_count++;
	end

	// shortest plan keeps busy up for two cycles
	busy_falls_after_high: assert property (@(posedge clk) disable iff (i_rst)
		$fell(i_busy) |-> $past(i_busy, 2))
	else
	begin
		$error("o_busy fell without having been high");
		fail_count++;
	end

	sum_count_in_range: assert property (@(posedge clk) disable iff (i_rst)
		i_sum_count <= 4'd8)
	else
	begin
		$error("o_sum_count above eight");
		fail_count++;
	end

endmodule

bind psum_collect_top psum_collect_checker u_checker (
	.clk         (clk),
	.i_rst       (i_rst),
	.i_busy      (o_busy),
	.i_sum_valid (o_sum_valid),
	.i_sum_count (o_sum_count)
);

/* verification/psum_collect_tb.sv */
`timescale 1ns/1ps

module psum_collect_tb;
	import collect_pkg::*;

	localparam int DATA_W      = 32;
	localparam int SUM_W       = DATA_W + 3;
	localparam int NUM_TESTS   = 6;
	localparam int CYCLE_LIMIT = NUM_TESTS * 40;

	logic                        clk;
	logic                        i_rst;
	logic                        i_start;
	collect_plan_t               i_plan;
	logic [NUM_LANES-1:0]        i_lane_valid;
	logic [NUM_LANES*DATA_W-1:0] i_lane_data;
	logic                        i_hold;
	logic                        o_busy;
	logic                        o_sum_valid;
	logic [SUM_W-1:0]            o_sum;
	logic [3:0]                  o_sum_count;

	int               seed;
	int               errors;
	int               cycles;
	int               sum_pulses;
	int               test_err_start;
	int               tests_passed;
	int               tests_failed;
	logic [SUM_W-1:0] exp_sum_q[$];
	logic [3:0]       exp_cnt_q[$];
	string            name_q[$];
	string            chk_name;
	logic [SUM_W-1:0] chk_sum;
	logic [3:0]       chk_cnt;

	psum_collect_top #(.DATA_WIDTH(DATA_W), .FIFO_DEPTH(4), .SUM_WIDTH(SUM_W)) DUT (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_start      (i_start),
		.i_plan       (i_plan),
		.i_lane_valid (i_lane_valid),
		.i_lane_data  (i_lane_data),
		.i_hold       (i_hold),
		.o_busy       (o_busy),
		.o_sum_valid  (o_sum_valid),
		.o_sum        (o_sum),
		.o_sum_count  (o_sum_count)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// sum of valid planned lanes, repeats counted each time
	function automatic void model_plan(input collect_plan_t plan,
			input logic [NUM_LANES-1:0] valid, input logic [NUM_LANES*DATA_W-1:0] data,
			output logic [SUM_W-1:0] sum, output logic [3:0] cnt);
		lane_idx_t lane;
		sum = '0;
		cnt = '0;
		for (int k = 0; k < plan.count; k++)
		begin
			lane = plan.order[k];
			if (valid[lane])
			begin
				sum = sum + SUM_W'(data[lane*DATA_W +: DATA_W]);
				cnt = cnt + 4'd1;
			end
		end
	endfunction

	task automatic randomize_lanes(input logic [NUM_LANES-1:0] valid);
		for (int k = 0; k < NUM_LANES; k++)
			i_lane_data[k*DATA_W +: DATA_W] = $random(seed);
		i_lane_valid = valid;
	endtask

	task automatic expect_plan(input string name, input collect_plan_t plan);
		logic [SUM_W-1:0] s;
		logic [3:0]       c;
		model_plan(plan, i_lane_valid, i_lane_data, s, c);
		exp_sum_q.push_back(s);
		exp_cnt_q.push_back(c);
		name_q.push_back(name);
	endtask

	// caller sits 2 ns after an edge
	task automatic start_plan(input collect_plan_t plan);
		i_plan  = plan;
		i_start = 1'b1;
		@(posedge clk);
		#2;
		i_start = 1'b0;
	endtask

	task automatic wait_idle;
		while (o_busy)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic drain_results;
		while (exp_sum_q.size() != 0)
			@(negedge clk);
		@(posedge clk);
		#2;
	endtask

	task automatic report_test(input string name);
		if (errors == test_err_start)
		begin
			tests_passed++;
			$display("%s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - test_err_start);
		end
		test_err_start = errors;
	endtask

	// outputs are registered, look at them mid-cycle
	always @(negedge clk)
	begin
		if (!i_rst && o_sum_valid)
		begin
			sum_pulses++;
			if (exp_sum_q.size() == 0)
			begin
				$display("result pulse arrived with no plan outstanding");
				errors++;
			end
			else
			begin
				chk_name = name_q.pop_front();
				chk_sum  = exp_sum_q.pop_front();
				chk_cnt  = exp_cnt_q.pop_front();
				assert (o_sum == chk_sum) else
				begin
					$display("MISMATCH %s sum expected %0h actual %0h", chk_name, chk_sum, o_sum);
					errors++;
				end
				assert (o_sum_count == chk_cnt) else
				begin
					$display("MISMATCH %s count expected %0d actual %0d", chk_name, chk_cnt,
						o_sum_count);
					errors++;
				end
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout after %0d cycles, %0d results outstanding", cycles,
				exp_sum_q.size());
			$display("TEST FAILED");
			$finish;
		end
	end

	initial
	begin
		collect_plan_t p;
		logic [31:0]   r;
		int            pulses_start;
		seed           = 26;
		errors         = 0;
		cycles         = 0;
		sum_pulses     = 0;
		test_err_start = 0;
		tests_passed   = 0;
		tests_failed   = 0;
		i_rst          = 1'b1;
		i_start        = 1'b0;
		i_plan         = '0;
		i_lane_valid   = '0;
		i_lane_data    = '0;
		i_hold         = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		i_rst = 1'b0;
		@(posedge clk);
		#2;

		// all eight lanes in reverse order
		randomize_lanes(8'hff);
		p.count = 4'd8;
		for (int k = 0; k < NUM_LANES; k++)
			p.order[k] = lane_idx_t'(7 - k);
		expect_plan("full_plan", p);
		start_plan(p);
		drain_results();
		report_test("full_plan");

		randomize_lanes(8'b1010_0110);
		for (int k = 0; k < NUM_LANES; k++)
			p.order[k] = lane_idx_t'(k);
		expect_plan("invalid_lanes", p);
		start_plan(p);
		drain_results();
		report_test("invalid_lanes");

		// lane 2 three times, trailing 7s fall outside count
		randomize_lanes(8'b1111_1101);
		p.count = 4'd5;
		p.order = {3'd7, 3'd7, 3'd7, 3'd1, 3'd2, 3'd5, 3'd2, 3'd2};
		expect_plan("repeat_lane", p);
		start_plan(p);
		drain_results();
		report_test("repeat_lane");

		randomize_lanes(8'hff);
		p.count = 4'd8;
		p.order = {3'd3, 3'd6, 3'd0, 3'd5, 3'd1, 3'd7, 3'd2, 3'd4};
		pulses_start = sum_pulses;
		expect_plan("backpressure", p);
		start_plan(p);
		i_hold = 1'b1;
		repeat (20) @(posedge clk);
		#2;
		i_hold = 1'b0;
		drain_results();
		repeat (3) @(posedge clk);
		#2;
		assert (sum_pulses - pulses_start == 1) else
		begin
			$display("backpressure saw %0d result pulses instead of one",
				sum_pulses - pulses_start);
			errors++;
		end
		report_test("backpressure");

		for (int n = 0; n < 4; n++)
		begin
			wait_idle();
			r = $random(seed);
			randomize_lanes(r[15:8]);
			p.count = {1'b0, r[2:0]} + 4'd1;
			r = $random(seed);
			p.order = r[23:0];
			expect_plan($sformatf("back_to_back_%0d", n), p);
			start_plan(p);
		end
		drain_results();
		report_test("back_to_back");

		// held so nothing reaches the output before the reset
		randomize_lanes(8'hff);
		p.count = 4'd8;
		i_hold = 1'b1;
		start_plan(p);
		repeat (3) @(posedge clk);
		#2;
		i_rst = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		i_rst  = 1'b0;
		i_hold = 1'b0;
		assert (!o_busy) else
		begin
			$display("o_busy still high after reset in the middle of a plan");
			errors++;
		end
		randomize_lanes(8'b0111_1011);
		expect_plan("reset_mid_plan", p);
		start_plan(p);
		drain_results();
		report_test("reset_mid_plan");

		$display("tests passed %0d, tests failed %0d, checker failures %0d", tests_passed,
			tests_failed, DUT.u_checker.fail_count);
		if (errors == 0 && tests_failed == 0 && DUT.u_checker.fail_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
